/* logic/datapath_pkg.sv */
// datapath package: widths, opcodes, instruction fields and stage records for the scalar core
package datapath_pkg;

    // widths
    localparam int WORD_W   = 16;
    localparam int PC_W     = 8;
    localparam int REG_W    = 3;
    localparam int OP_W     = 4;
    localparam int NUM_REGS = 8;

    // instruction field positions
    localparam int OPCODE_HI = 15;
    localparam int OPCODE_LO = 12;
    localparam int RD_HI     = 11;
    localparam int RD_LO     = 9;
    localparam int RS1_HI    = 8;
    localparam int RS1_LO    = 6;
    localparam int RS2_HI    = 5;
    localparam int RS2_LO    = 3;
    localparam int IMM6_HI   = 5;
    localparam int IMM6_LO   = 0;
    localparam int IMM9_HI   = 8;
    localparam int IMM9_LO   = 0;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [PC_W-1:0]   pc_t;
    typedef logic [REG_W-1:0]  reg_sel_t;

    // codes not listed here decode as a NOP
    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_XOR  = 4'h3,
        OP_ADDI = 4'h4,
        OP_BEQ  = 4'h5,
        OP_JAL  = 4'h6,
        OP_HALT = 4'hF
    } opcode_t;

    typedef enum logic [1:0] {
        SB_RUN,
        SB_HOLD,
        SB_HALTED
    } sb_state_t;

    // fetch -> scoreboard latch
    typedef struct packed {
        logic  valid;
        word_t instr;
        pc_t   pc;
    } fetch_t;

    // scoreboard issue register, read by execute
    typedef struct packed {
        logic     valid;
        opcode_t  op;
        reg_sel_t rd;
        word_t    rdat1;
        word_t    rdat2;
        word_t    imm;
        pc_t      pc;
    } issue_t;

    typedef struct packed {
        logic     done;
        reg_sel_t reg_sel;
        word_t    wdat;
    } ex_t;

    typedef struct packed {
        logic taken;
        pc_t  target;
    } redirect_t;

    // writeback record, also the commit trace
    typedef struct packed {
        logic     wen;
        reg_sel_t reg_sel;
        word_t    wdat;
    } wb_t;

endpackage

/* logic/fetch_stage.sv */
// fetch stage: program counter and instruction memory request with ihit wait and redirect
`timescale 1ns/1ps

module fetch_stage import datapath_pkg::*; (
    input  logic      CLK,
    input  logic      nrst,
    input  logic      ihit,
    input  word_t     imemload,
    input  logic      freeze,
    input  redirect_t redirect,
    input  logic      halt,
    output logic      imemREN,
    output pc_t       imemaddr,
    output fetch_t    fetch_out
);

    pc_t  pc;
    logic accept;

    // request stays up with a stable address until ihit comes back
    assign imemREN  = !halt;
    assign imemaddr = pc;

    // word is taken only when the scoreboard can move and no redirect is pending
    assign accept = ihit && imemREN && !freeze && !redirect.taken;

    always_comb begin
        fetch_out       = '0;
        fetch_out.valid = accept;
        fetch_out.instr = imemload;
        fetch_out.pc    = pc;
    end

    // redirect overrides both the wait and a normal advance
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            pc <= '0;
        end
        else if (redirect.taken) begin
            pc <= redirect.target;
        end
        else if (accept) begin
            pc <= pc + pc_t'(1);
        end
    end

endmodule

/* logic/scoreboard.sv */
// scoreboard: decode, register file, busy tracking, hazard hold and the issue register
`timescale 1ns/1ps

module scoreboard import datapath_pkg::*; (
    input  logic      CLK,
    input  logic      nrst,
    input  fetch_t    fetch_in,
    input  wb_t       wb,
    input  redirect_t redirect,
    output logic      freeze,
    output issue_t    issue
);

    word_t                regs [NUM_REGS];
    logic  [NUM_REGS-1:0] busy;
    logic  [NUM_REGS-1:0] busy_next;

    sb_state_t state;
    sb_state_t state_next;

    // decoded fields
    opcode_t  op;
    reg_sel_t rd;
    reg_sel_t src_a;
    reg_sel_t src_b;
    word_t    imm;
    logic     uses_a;
    logic     uses_b;
    logic     writes_rd;

    logic hazard;
    logic issue_go;

    always_comb begin
        op        = opcode_t'(fetch_in.instr[OPCODE_HI:OPCODE_LO]);
        rd        = fetch_in.instr[RD_HI:RD_LO];
        src_a     = fetch_in.instr[RS1_HI:RS1_LO];
        src_b     = fetch_in.instr[RS2_HI:RS2_LO];
        imm       = {{(WORD_W-6){fetch_in.instr[IMM6_HI]}}, fetch_in.instr[IMM6_HI:IMM6_LO]};
        uses_a    = 1'b0;
        uses_b    = 1'b0;
        writes_rd = 1'b0;
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                uses_a    = 1'b1;
                uses_b    = 1'b1;
                writes_rd = 1'b1;
            end
            OP_ADDI: begin
                uses_a    = 1'b1;
                writes_rd = 1'b1;
            end
            // beq compares the rd and rs1 fields
            OP_BEQ: begin
                src_a  = fetch_in.instr[RD_HI:RD_LO];
                src_b  = fetch_in.instr[RS1_HI:RS1_LO];
                uses_a = 1'b1;
                uses_b = 1'b1;
            end
            OP_JAL: begin
                writes_rd = 1'b1;
                imm = {{(WORD_W-9){fetch_in.instr[IMM9_HI]}},
                       fetch_in.instr[IMM9_HI:IMM9_LO]};
            end
            default: begin
            end
        endcase
    end

    // any busy source or destination blocks issue until writeback clears it
    assign hazard = (uses_a && busy[src_a]) || (uses_b && busy[src_b])
                 || (writes_rd && busy[rd]);

    assign issue_go = fetch_in.valid && !hazard && !redirect.taken && (state != SB_HALTED);
    assign freeze   = (fetch_in.valid && hazard) || (state == SB_HALTED);

    always_comb begin
        state_next = state;
        if (state != SB_HALTED) begin
            if (redirect.taken) begin
                state_next = SB_RUN;
            end
            else if (fetch_in.valid && hazard) begin
                state_next = SB_HOLD;
            end
            else if (issue_go && op == OP_HALT) begin
                state_next = SB_HALTED;
            end
            else begin
                state_next = SB_RUN;
            end
        end
    end

    // clear from writeback, set on issue of a register writer
    always_comb begin
        busy_next = busy;
        if (wb.wen) begin
            busy_next[wb.reg_sel] = 1'b0;
        end
        if (issue_go && writes_rd) begin
            busy_next[rd] = 1'b1;
        end
    end

    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            state <= SB_RUN;
            busy  <= '0;
            issue <= '0;
        end
        else begin
            state <= state_next;
            busy  <= busy_next;
            issue <= '0;
            if (issue_go) begin
                issue.valid <= 1'b1;
                issue.op    <= op;
                issue.rd    <= rd;
                issue.rdat1 <= regs[src_a];
                issue.rdat2 <= regs[src_b];
                issue.imm   <= imm;
                issue.pc    <= fetch_in.pc;
            end
        end
    end

    // single write port, driven by writeback
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            regs <= '{default: '0};
        end
        else if (wb.wen) begin
            regs[wb.reg_sel] <= wb.wdat;
        end
    end

endmodule

/* logic/execute.sv */
// execute stage: ALU, branch and jump resolution, sticky halt flag
`timescale 1ns/1ps

module execute import datapath_pkg::*; (
    input  logic      CLK,
    input  logic      nrst,
    input  issue_t    issue,
    output ex_t       ex_out,
    output redirect_t redirect,
    output logic      halt
);

    word_t result;
    logic  writes;
    logic  taken;
    pc_t   target;
    pc_t   pc_plus1;
    logic  halt_now;
    logic  halt_q;

    // branch offsets are word offsets, only the low bits reach the pc
    assign target   = issue.pc + pc_t'(issue.imm);
    assign pc_plus1 = issue.pc + pc_t'(1);

    always_comb begin
        result = '0;
        writes = 1'b0;
        taken  = 1'b0;
        case (issue.op)
            OP_ADD: begin
                result = issue.rdat1 + issue.rdat2;
                writes = 1'b1;
            end
            OP_SUB: begin
                result = issue.rdat1 - issue.rdat2;
                writes = 1'b1;
            end
            OP_AND: begin
                result = issue.rdat1 & issue.rdat2;
                writes = 1'b1;
            end
            OP_XOR: begin
                result = issue.rdat1 ^ issue.rdat2;
                writes = 1'b1;
            end
            OP_ADDI: begin
                result = issue.rdat1 + issue.imm;
                writes = 1'b1;
            end
            OP_BEQ: begin
                taken = (issue.rdat1 == issue.rdat2);
            end
            // link value is the return address
            OP_JAL: begin
                result = {{(WORD_W-PC_W){1'b0}}, pc_plus1};
                writes = 1'b1;
                taken  = 1'b1;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        ex_out          = '0;
        ex_out.done     = issue.valid && writes;
        ex_out.reg_sel  = issue.rd;
        ex_out.wdat     = result;
        redirect        = '0;
        redirect.taken  = issue.valid && taken;
        redirect.target = target;
    end

    assign halt_now = issue.valid && (issue.op == OP_HALT);
    assign halt     = halt_q || halt_now;

    // stays set until reset
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            halt_q <= 1'b0;
        end
        else if (halt_now) begin
            halt_q <= 1'b1;
        end
    end

endmodule

/* logic/writeback.sv */
// writeback stage: latches the completing result as the register write and busy clear record
`timescale 1ns/1ps

module writeback import datapath_pkg::*; (
    input  logic CLK,
    input  logic nrst,
    input  ex_t  ex_in,
    output wb_t  wb
);

    wb_t wb_q;

    // data only moves on a completing result, wen drops in idle cycles
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            wb_q <= '0;
        end
        else begin
            wb_q.wen <= ex_in.done;
            if (ex_in.done) begin
                wb_q.reg_sel <= ex_in.reg_sel;
                wb_q.wdat    <= ex_in.wdat;
            end
        end
    end

    // one write port serves the register file, the busy clear and commit
    assign wb = wb_q;

endmodule

/* logic/sc_datapath.sv */
// scalar datapath top: fetch, scoreboard, execute and writeback with the inter-stage latches
`timescale 1ns/1ps

module sc_datapath import datapath_pkg::*; (
    input  logic  CLK,
    input  logic  nrst,
    input  logic  ihit,
    input  word_t imemload,
    output logic  imemREN,
    output pc_t   imemaddr,
    output logic  halt,
    output wb_t   commit
);

    fetch_t    fetch_out;
    fetch_t    fetch_q;
    issue_t    issue;
    ex_t       ex_out;
    wb_t       wb_q;
    redirect_t redirect;
    logic      freeze;

    fetch_stage fetch_stage_inst (
        .CLK       (CLK),
        .nrst      (nrst),
        .ihit      (ihit),
        .imemload  (imemload),
        .freeze    (freeze),
        .redirect  (redirect),
        .halt      (halt),
        .imemREN   (imemREN),
        .imemaddr  (imemaddr),
        .fetch_out (fetch_out)
    );

    scoreboard scoreboard_inst (
        .CLK      (CLK),
        .nrst     (nrst),
        .fetch_in (fetch_q),
        .wb       (wb_q),
        .redirect (redirect),
        .freeze   (freeze),
        .issue    (issue)
    );

    execute execute_inst (
        .CLK      (CLK),
        .nrst     (nrst),
        .issue    (issue),
        .ex_out   (ex_out),
        .redirect (redirect),
        .halt     (halt)
    );

    // holds the execute -> writeback latch
    writeback writeback_inst (
        .CLK   (CLK),
        .nrst  (nrst),
        .ex_in (ex_out),
        .wb    (wb_q)
    );

    // fetch -> scoreboard latch
    // squashed on a taken branch, held while the scoreboard stalls
    always_ff @(posedge CLK, negedge nrst) begin
        if (!nrst) begin
            fetch_q <= '0;
        end
        else if (redirect.taken) begin
            fetch_q <= '0;
        end
        else if (!freeze) begin
            fetch_q <= fetch_out;
        end
    end

    // every register write leaves as a commit record
    assign commit = wb_q;

endmodule

/* testbench/tb_sc_datapath.sv */
// testbench for the scalar datapath: program ROM, memory model, golden model and commit checks
`timescale 1ns/1ps

module tb_sc_datapath import datapath_pkg::*; ();

    localparam int ROM_WORDS   = 64;
    localparam int NUM_RANDOM  = 24;
    localparam int RANDOM_BASE = 18;
    localparam int CLK_PERIOD  = 4;
    localparam int WATCHDOG_NS = ROM_WORDS * 12 * CLK_PERIOD + 1000;

    logic  CLK;
    logic  nrst;
    logic  ihit;
    word_t imemload;
    logic  imemREN;
    pc_t   imemaddr;
    logic  halt;
    wb_t   commit;

    word_t rom [ROM_WORDS];
    wb_t   expected [$];
    int    commit_cnt = 0;
    logic  halt_seen  = 1'b0;

    sc_datapath sc_datapath_inst (
        .CLK      (CLK),
        .nrst     (nrst),
        .ihit     (ihit),
        .imemload (imemload),
        .imemREN  (imemREN),
        .imemaddr (imemaddr),
        .halt     (halt),
        .commit   (commit)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) CLK = ~CLK;
        end
    end

    task automatic end_with_failure(string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "testbench stopped on a failed check");
    endtask

    task automatic flag_mismatch(string msg);
        end_with_failure($sformatf("** Error at %0t: %s", $time, msg));
    endtask

    function automatic word_t encode_reg_op(opcode_t op, reg_sel_t rd, reg_sel_t rs1,
                                            reg_sel_t rs2);
        return {op, rd, rs1, rs2, 3'b000};
    endfunction

    function automatic word_t encode_imm_op(opcode_t op, reg_sel_t rd, reg_sel_t rs1,
                                            logic [5:0] imm6);
        return {op, rd, rs1, imm6};
    endfunction

    function automatic word_t encode_jal(reg_sel_t rd, logic [8:0] imm9);
        return {OP_JAL, rd, imm9};
    endfunction

    // addresses past the ROM read as HALT
    function automatic word_t rom_word(pc_t addr);
        if (int'(addr) < ROM_WORDS) begin
            return rom[addr[5:0]];
        end
        return {OP_HALT, 12'h000};
    endfunction

    task automatic build_rom();
        // dependent chain, read-after-write and write-after-write on r3
        rom[0]  = encode_imm_op(OP_ADDI, 3'd1, 3'd0, 6'd5);
        rom[1]  = encode_imm_op(OP_ADDI, 3'd2, 3'd1, 6'd3);
        rom[2]  = encode_reg_op(OP_ADD, 3'd3, 3'd1, 3'd2);
        rom[3]  = encode_reg_op(OP_ADD, 3'd3, 3'd3, 3'd3);
        rom[4]  = encode_reg_op(OP_SUB, 3'd4, 3'd3, 3'd1);
        rom[5]  = encode_reg_op(OP_XOR, 3'd5, 3'd4, 3'd2);
        rom[6]  = encode_reg_op(OP_AND, 3'd6, 3'd5, 3'd3);
        rom[7]  = encode_imm_op(OP_ADDI, 3'd3, 3'd3, 6'h3F);
        // r1 != r2 here, falls through
        rom[8]  = encode_imm_op(OP_BEQ, 3'd1, 3'd2, 6'd5);
        rom[9]  = encode_imm_op(OP_ADDI, 3'd7, 3'd0, 6'd2);
        rom[10] = encode_imm_op(OP_BEQ, 3'd7, 3'd7, 6'd3);
        rom[11] = encode_imm_op(OP_ADDI, 3'd1, 3'd0, 6'd31);
        rom[12] = encode_imm_op(OP_ADDI, 3'd2, 3'd0, 6'd31);
        rom[13] = encode_jal(3'd6, 9'd4);
        rom[14] = encode_imm_op(OP_ADDI, 3'd5, 3'd0, 6'd17);
        rom[15] = encode_imm_op(OP_ADDI, 3'd5, 3'd0, 6'd18);
        rom[16] = encode_reg_op(OP_XOR, 3'd5, 3'd5, 3'd5);
        rom[17] = encode_imm_op(OP_ADDI, 3'd0, 3'd6, 6'd1);
        // random ALU ops, opcodes 0 to 4 only
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rom[RANDOM_BASE + i] = {4'($urandom_range(4, 0)), 12'($urandom())};
        end
        rom[42] = encode_imm_op(OP_BEQ, 3'd0, 3'd0, 6'd2);
        rom[43] = encode_imm_op(OP_ADDI, 3'd1, 3'd1, 6'd1);
        rom[44] = encode_jal(3'd7, 9'd3);
        rom[45] = encode_reg_op(OP_SUB, 3'd7, 3'd7, 3'd7);
        rom[46] = encode_imm_op(OP_ADDI, 3'd7, 3'd0, 6'd9);
        rom[47] = encode_reg_op(OP_ADD, 3'd2, 3'd7, 3'd7);
        // tail chain, each op reads the one before it
        for (int a = 48; a < ROM_WORDS - 1; a++) begin
            rom[a] = encode_imm_op(OP_ADDI, 3'(a), 3'(a - 1), 6'(a));
        end
        rom[ROM_WORDS - 1] = {OP_HALT, 12'h000};
    endtask

    // sequential reference execution of the ROM
    task automatic build_expected();
        word_t    regs [NUM_REGS];
        pc_t      pc;
        pc_t      link;
        word_t    instr;
        word_t    a;
        word_t    imm6;
        word_t    imm9;
        word_t    res;
        reg_sel_t rd;
        logic     writes;
        logic     stop;
        int       steps;
        wb_t      rec;
        regs  = '{default: '0};
        pc    = '0;
        stop  = 1'b0;
        steps = 0;
        while (!stop) begin
            instr  = rom_word(pc);
            rd     = instr[RD_HI:RD_LO];
            a      = regs[instr[RS1_HI:RS1_LO]];
            imm6   = {{(WORD_W-6){instr[IMM6_HI]}}, instr[IMM6_HI:IMM6_LO]};
            imm9   = {{(WORD_W-9){instr[IMM9_HI]}}, instr[IMM9_HI:IMM9_LO]};
            link   = pc + pc_t'(1);
            writes = 1'b1;
            res    = '0;
            case (opcode_t'(instr[OPCODE_HI:OPCODE_LO]))
                OP_ADD:  res = a + regs[instr[RS2_HI:RS2_LO]];
                OP_SUB:  res = a - regs[instr[RS2_HI:RS2_LO]];
                OP_AND:  res = a & regs[instr[RS2_HI:RS2_LO]];
                OP_XOR:  res = a ^ regs[instr[RS2_HI:RS2_LO]];
                OP_ADDI: res = a + imm6;
                OP_BEQ: begin
                    writes = 1'b0;
                    if (regs[rd] == a) begin
                        link = pc + pc_t'(imm6);
                    end
                end
                OP_JAL: begin
                    res  = {{(WORD_W-PC_W){1'b0}}, link};
                    link = pc + pc_t'(imm9);
                end
                OP_HALT: begin
                    writes = 1'b0;
                    stop   = 1'b1;
                end
                default: writes = 1'b0;
            endcase
            if (writes) begin
                regs[rd]    = res;
                rec.wen     = 1'b1;
                rec.reg_sel = rd;
                rec.wdat    = res;
                expected.push_back(rec);
            end
            pc    = link;
            steps = steps + 1;
            if (steps > 4 * ROM_WORDS) begin
                end_with_failure("reference model never reached HALT in the program ROM");
            end
        end
    endtask

    task automatic check_reset_outputs();
        assert (halt == 1'b0) else flag_mismatch("halt is set in reset");
        assert (commit.wen == 1'b0) else flag_mismatch("commit.wen is set in reset");
        assert (imemREN == 1'b1) else flag_mismatch("imemREN is low in reset");
        assert (imemaddr == '0) else flag_mismatch($sformatf("imemaddr %h in reset", imemaddr));
    endtask

    // instruction memory, one strobe per word after 0 to 2 idle cycles
    initial begin : imem_model
        int delay;
        ihit     = 1'b0;
        imemload = '0;
        delay    = 0;
        forever begin
            @(negedge CLK);
            if (imemREN && delay == 0) begin
                ihit     = 1'b1;
                imemload = rom_word(imemaddr);
                delay    = $urandom_range(2, 0);
            end
            else begin
                ihit = 1'b0;
                if (delay > 0) begin
                    delay = delay - 1;
                end
            end
        end
    end

    // commit trace and halt behaviour, sampled away from the active edge
    always @(negedge CLK) begin
        if (nrst) begin
            if (commit.wen) begin
                assert (commit_cnt < expected.size())
                else flag_mismatch($sformatf("extra commit r%0d = %h beyond %0d writes",
                    commit.reg_sel, commit.wdat, expected.size()));
                assert (commit == expected[commit_cnt])
                else flag_mismatch($sformatf("commit %0d is r%0d = %h, expected r%0d = %h",
                    commit_cnt, commit.reg_sel, commit.wdat,
                    expected[commit_cnt].reg_sel, expected[commit_cnt].wdat));
                commit_cnt = commit_cnt + 1;
            end
            assert (!(halt && imemREN)) else flag_mismatch("imemREN high while halted");
            if (halt_seen) begin
                assert (halt) else flag_mismatch("halt dropped after it was raised");
            end
            if (halt) begin
                halt_seen = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        end_with_failure($sformatf("watchdog expired after %0d ns, program did not finish",
            WATCHDOG_NS));
    end

    initial begin
        nrst = 1'b0;
        void'($urandom(1439));
        build_rom();
        build_expected();
        repeat (2) begin
            @(negedge CLK);
            check_reset_outputs();
        end
        nrst = 1'b1;
        check_reset_outputs();
        wait (halt_seen == 1'b1);
        // a few more cycles so a stray commit after halt is still caught
        repeat (3) @(posedge CLK);
        if (commit_cnt == expected.size()) begin
            $display("Simulation completed successfully");
            $finish;
        end
        else begin
            flag_mismatch($sformatf("saw %0d commits, expected %0d",
                commit_cnt, expected.size()));
        end
    end

endmodule

/* project.f */
logic/datapath_pkg.sv
logic/fetch_stage.sv
logic/scoreboard.sv
logic/execute.sv
logic/writeback.sv
logic/sc_datapath.sv
testbench/tb_sc_datapath.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module tb_sc_datapath -o tb_sc_datapath &&
./obj_dir/tb_sc_datapath ||
{ echo "datapath simulation did not pass"; exit 1; }
